//--- list.f
+incdir+verif
logic/ffcp_pkg.sv
logic/fgp_byte_counter.sv
logic/packet_buffer_ram.sv
logic/ffcp_rx_fsm.sv
logic/fragment_streamer.sv
logic/ffcp_rx_top.sv
verif/ffcp_rx_assertions.sv
verif/ffcp_rx_tb.sv

//--- logic/ffcp_pkg.sv
`default_nettype none

package ffcp_pkg;

	// One byte on the framer interface or in the packet buffer
	typedef logic [7:0] byte_t;

	// Ethertype as handed over by the Ethernet framer
	typedef logic [15:0] ethertype_t;

	// First FFCP header byte
	typedef logic [7:0] ffcp_type_t;

	// Second FFCP header byte, echoed back in the ack
	typedef logic [7:0] ffcp_index_t;

	// Ethertype that marks an FFCP frame
	localparam ethertype_t ETHERTYPE_FFCP = 16'h88b5;

	// Packet type codes
	localparam ffcp_type_t FFCP_TYPE_ACK = 8'd1;
	localparam ffcp_type_t FFCP_TYPE_SYN = 8'd2;
	localparam ffcp_type_t FFCP_TYPE_MSG = 8'd3;

	// Only SYN and MSG frames carry a fragment
	// ACK frames belong to the transmit side and are ignored here

	// Frame layout after the ethertype
	//   byte 0          packet type
	//   byte 1          packet index
	//   byte 2 onwards  exactly FGP_LEN payload bytes

	// The buffer slot of a fragment is the low bits of its index,
	// so slots are reused once the index wraps around SLOT_COUNT

endpackage

`default_nettype wire

//--- logic/ffcp_rx_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module ffcp_rx_fsm import ffcp_pkg::*; #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16
) (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input wire logic ethertype_valid,
	input wire ethertype_t ethertype,
	input wire logic in_valid,
	input wire byte_t in_data,
	input wire logic frame_done,
	input wire logic count_full,
	input wire logic count_overflow,
	input wire logic commit_ready,
	output logic count_clear,
	output logic count_step,
	output logic wr_en,
	output logic [$clog2(SLOT_COUNT)-1:0] wr_slot,
	output byte_t wr_data,
	output logic commit_req,
	output logic [$clog2(SLOT_COUNT)-1:0] commit_slot,
	output ffcp_index_t commit_index,
	output logic commit_syn
);

	localparam int SLOT_W = $clog2(SLOT_COUNT);

	typedef enum logic [2:0] {
		IDLE,
		TYPE,
		INDEX,
		PAYLOAD,
		DROP,
		COMMIT
	} state_t;

	state_t state;
	state_t state_next;
	ffcp_index_t index_q;
	logic syn_q;
	logic accept;

	// Slot and offset addressing relies on both sizes being powers of two
	if ((FGP_LEN & (FGP_LEN - 1)) != 0) begin : g_fgp_len_check
		$error("FGP_LEN must be a power of two");
	end
	if ((SLOT_COUNT & (SLOT_COUNT - 1)) != 0) begin : g_slot_count_check
		$error("SLOT_COUNT must be a power of two");
	end

	// Exactly FGP_LEN payload bytes
	assign accept = count_full && !count_overflow;

	always_comb begin
		state_next = state;
		case (state)
			IDLE:
				if (ethertype_valid && ethertype == ETHERTYPE_FFCP)
					state_next = TYPE;
			TYPE:
				if (frame_done)
					state_next = IDLE;
				else if (in_valid)
					state_next = (in_data == FFCP_TYPE_SYN || in_data == FFCP_TYPE_MSG) ?
						INDEX : DROP;
			INDEX:
				if (frame_done)
					state_next = IDLE;
				else if (in_valid)
					state_next = PAYLOAD;
			PAYLOAD:
				if (frame_done)
					state_next = accept ? COMMIT : IDLE;
			DROP:
				if (frame_done)
					state_next = IDLE;
			COMMIT:
				if (commit_ready)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (state == TYPE && in_valid)
			syn_q <= in_data == FFCP_TYPE_SYN;
		if (state == INDEX && in_valid)
			index_q <= in_data;
	end

	// Counter restarts after a drop or once the fragment is handed off
	assign count_clear = (frame_done && (state == DROP || (state == PAYLOAD && !accept))) ||
		(state == COMMIT && commit_ready);
	assign count_step = state == PAYLOAD && in_valid;

	// Excess bytes are counted but never written
	assign wr_en = count_step && !count_full;
	assign wr_slot = index_q[SLOT_W-1:0];
	assign wr_data = in_data;

	assign commit_req = state == COMMIT;
	assign commit_slot = index_q[SLOT_W-1:0];
	assign commit_index = index_q;
	assign commit_syn = syn_q;

endmodule

`default_nettype wire

//--- logic/ffcp_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module ffcp_rx_top import ffcp_pkg::*; #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16,
	parameter int CREDIT_MAX = 4
) (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input wire logic ethertype_valid,
	input wire ethertype_t ethertype,
	input wire logic in_valid,
	input wire byte_t in_data,
	input wire logic frame_done,
	input wire logic out_credit,
	output logic out_valid,
	output byte_t out_data,
	output logic ack_valid,
	output ffcp_index_t ack_index,
	output logic ack_syn
);

	localparam int SLOT_W = $clog2(SLOT_COUNT);
	localparam int OFF_W = $clog2(FGP_LEN);

	// Byte counter
	logic count_clear;
	logic count_step;
	logic [OFF_W-1:0] count;
	logic count_full;
	logic count_overflow;

	// Buffer write side
	logic wr_en;
	logic [SLOT_W-1:0] wr_slot;
	byte_t wr_data;

	// Commit hand-off
	logic commit_req;
	logic commit_ready;
	logic [SLOT_W-1:0] commit_slot;
	ffcp_index_t commit_index;
	logic commit_syn;

	// Buffer read side
	logic [SLOT_W-1:0] rd_slot;
	logic [OFF_W-1:0] rd_offset;
	byte_t rd_data;

	ffcp_rx_fsm #(
		.FGP_LEN(FGP_LEN),
		.SLOT_COUNT(SLOT_COUNT)
	) ffcp_rx_fsm_inst (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ethertype_valid(ethertype_valid),
		.ethertype(ethertype),
		.in_valid(in_valid),
		.in_data(in_data),
		.frame_done(frame_done),
		.count_full(count_full),
		.count_overflow(count_overflow),
		.commit_ready(commit_ready),
		.count_clear(count_clear),
		.count_step(count_step),
		.wr_en(wr_en),
		.wr_slot(wr_slot),
		.wr_data(wr_data),
		.commit_req(commit_req),
		.commit_slot(commit_slot),
		.commit_index(commit_index),
		.commit_syn(commit_syn)
	);

	fgp_byte_counter #(
		.FGP_LEN(FGP_LEN)
	) fgp_byte_counter_inst (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.clear(count_clear),
		.step(count_step),
		.count(count),
		.full(count_full),
		.overflow(count_overflow)
	);

	packet_buffer_ram #(
		.FGP_LEN(FGP_LEN),
		.SLOT_COUNT(SLOT_COUNT)
	) packet_buffer_ram_inst (
		.clk(clk),
		.wr_en(wr_en),
		.wr_slot(wr_slot),
		.wr_offset(count),
		.wr_data(wr_data),
		.rd_slot(rd_slot),
		.rd_offset(rd_offset),
		.rd_data(rd_data)
	);

	fragment_streamer #(
		.FGP_LEN(FGP_LEN),
		.SLOT_COUNT(SLOT_COUNT),
		.CREDIT_MAX(CREDIT_MAX)
	) fragment_streamer_inst (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.commit_req(commit_req),
		.commit_slot(commit_slot),
		.commit_index(commit_index),
		.commit_syn(commit_syn),
		.rd_data(rd_data),
		.out_credit(out_credit),
		.commit_ready(commit_ready),
		.rd_slot(rd_slot),
		.rd_offset(rd_offset),
		.out_valid(out_valid),
		.out_data(out_data),
		.ack_valid(ack_valid),
		.ack_index(ack_index),
		.ack_syn(ack_syn)
	);

endmodule

`default_nettype wire

//--- logic/fgp_byte_counter.sv
`timescale 1ns/100ps
`default_nettype none

module fgp_byte_counter import ffcp_pkg::*; #(
	parameter int FGP_LEN = 16
) (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input wire logic clear,
	input wire logic step,
	output logic [$clog2(FGP_LEN)-1:0] count,
	output logic full,
	output logic overflow
);

	localparam int CNT_W = $clog2(FGP_LEN) + 1;

	typedef logic [CNT_W-1:0] cnt_t;

	cnt_t cnt;

	assign full = cnt == cnt_t'(FGP_LEN);
	// In-slot address, only meaningful below FGP_LEN
	assign count = cnt[CNT_W-2:0];

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst || clear) begin
			cnt <= '0;
			overflow <= 1'b0;
		end else if (step) begin
			if (full)
				overflow <= 1'b1;
			else
				cnt <= cnt + cnt_t'(1);
		end
	end

endmodule

`default_nettype wire

//--- logic/fragment_streamer.sv
`timescale 1ns/100ps
`default_nettype none

module fragment_streamer import ffcp_pkg::*; #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16,
	parameter int CREDIT_MAX = 4
) (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input wire logic commit_req,
	input wire logic [$clog2(SLOT_COUNT)-1:0] commit_slot,
	input wire ffcp_index_t commit_index,
	input wire logic commit_syn,
	input wire byte_t rd_data,
	input wire logic out_credit,
	output logic commit_ready,
	output logic [$clog2(SLOT_COUNT)-1:0] rd_slot,
	output logic [$clog2(FGP_LEN)-1:0] rd_offset,
	output logic out_valid,
	output byte_t out_data,
	output logic ack_valid,
	output ffcp_index_t ack_index,
	output logic ack_syn
);

	localparam int SLOT_W = $clog2(SLOT_COUNT);
	localparam int OFF_W = $clog2(FGP_LEN);
	localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

	typedef logic [CREDIT_W-1:0] credit_t;

	logic busy;
	logic handoff;
	logic [SLOT_W-1:0] slot_q;
	ffcp_index_t index_q;
	logic syn_q;
	// Reads issued so far, one extra bit marks all FGP_LEN done
	logic [OFF_W:0] rd_cnt;
	logic [OFF_W-1:0] out_cnt;
	credit_t credits;
	logic rd_issue;
	logic last_byte;

	assign commit_ready = !busy;
	assign handoff = commit_req && commit_ready;

	// A read in flight this cycle already has a credit set aside
	assign rd_issue = busy && !rd_cnt[OFF_W] && (credits > credit_t'(out_valid));
	assign last_byte = out_valid && out_cnt == OFF_W'(FGP_LEN - 1);

	assign rd_slot = slot_q;
	assign rd_offset = rd_cnt[OFF_W-1:0];

	// Buffer output lines up with out_valid
	assign out_data = rd_data;

	assign ack_index = index_q;
	assign ack_syn = syn_q;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			busy <= 1'b0;
			rd_cnt <= '0;
			out_cnt <= '0;
			out_valid <= 1'b0;
			ack_valid <= 1'b0;
			credits <= credit_t'(CREDIT_MAX);
		end else begin
			out_valid <= rd_issue;
			ack_valid <= last_byte;
			credits <= credits + credit_t'(out_credit) - credit_t'(out_valid);
			if (handoff) begin
				busy <= 1'b1;
				rd_cnt <= '0;
				out_cnt <= '0;
			end else begin
				if (rd_issue)
					rd_cnt <= rd_cnt + 1'b1;
				if (out_valid)
					out_cnt <= out_cnt + 1'b1;
				if (last_byte)
					busy <= 1'b0;
			end
		end
	end

	// Fragment details stay put until the next hand-off
	always_ff @(posedge clk) begin
		if (handoff) begin
			slot_q <= commit_slot;
			index_q <= commit_index;
			syn_q <= commit_syn;
		end
	end

endmodule

`default_nettype wire

//--- logic/packet_buffer_ram.sv
`timescale 1ns/100ps
`default_nettype none

module packet_buffer_ram import ffcp_pkg::*; #(
	parameter int FGP_LEN = 16,
	parameter int SLOT_COUNT = 16
) (
	input wire logic clk,
	input wire logic wr_en,
	input wire logic [$clog2(SLOT_COUNT)-1:0] wr_slot,
	input wire logic [$clog2(FGP_LEN)-1:0] wr_offset,
	input wire byte_t wr_data,
	input wire logic [$clog2(SLOT_COUNT)-1:0] rd_slot,
	input wire logic [$clog2(FGP_LEN)-1:0] rd_offset,
	output byte_t rd_data
);

	localparam int DEPTH = SLOT_COUNT * FGP_LEN;

	byte_t mem [DEPTH];

	// Slot selects the upper address bits, offset the lower ones
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[{wr_slot, wr_offset}] <= wr_data;
		rd_data <= mem[{rd_slot, rd_offset}];
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the FFCP receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ffcp_rx_tb \
	-f list.f -o ffcp_rx_sim > build.log 2>&1 \
	&& ./obj_dir/ffcp_rx_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed, see build.log and sim.log"; }

cat sim.log 2>/dev/null
grep -q "^>>> PASS$" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/ffcp_rx_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module ffcp_rx_assertions #(
	parameter int CREDIT_MAX = 4
) (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input wire logic out_valid,
	input wire logic ack_valid,
	input wire logic [$clog2(CREDIT_MAX + 1)-1:0] credits
);

	// Every streamed byte is covered by a credit
	credit_available: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		out_valid |-> credits != '0)
		else $error("out_valid raised with no credit left");

	credit_bound: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		int'(credits) <= CREDIT_MAX)
		else $error("credit counter above CREDIT_MAX");

	ack_single_cycle: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		ack_valid |=> !ack_valid)
		else $error("ack_valid held for more than one cycle");

endmodule

`default_nettype wire

//--- verif/ffcp_rx_tests.svh
task automatic note_fail(input string line);
	$display("%s", line);
	test_errors = test_errors + 1;
endtask

// Called at time zero or right after a falling edge
task automatic apply_reset();
	eth_rx_downstream_rst = 1'b1;
	repeat (3) @(negedge clk);
	eth_rx_downstream_rst = 1'b0;
endtask

task automatic make_payload(input int len, output byte_t q[$]);
	int i;
	q.delete();
	for (i = 0; i < len; i++)
		q.push_back(byte_t'($urandom));
endtask

// Ethertype pulse, type, index, payload, then frame_done on its own cycle
task automatic drive_frame(input ethertype_t et, input ffcp_type_t typ, input ffcp_index_t idx,
		input byte_t payload[$], input bit with_done);
	int i;
	@(negedge clk);
	ethertype_valid = 1'b1;
	ethertype = et;
	@(negedge clk);
	ethertype_valid = 1'b0;
	in_valid = 1'b1;
	in_data = typ;
	@(negedge clk);
	in_data = idx;
	for (i = 0; i < payload.size(); i++) begin
		@(negedge clk);
		in_data = payload[i];
	end
	@(negedge clk);
	in_valid = 1'b0;
	frame_done = with_done;
	@(negedge clk);
	frame_done = 1'b0;
	@(negedge clk);
endtask

task automatic send_good(input ffcp_type_t typ, input ffcp_index_t idx);
	byte_t p[$];
	make_payload(FGP_LEN, p);
	foreach (p[i])
		exp_q.push_back(p[i]);
	drive_frame(ETHERTYPE_FFCP, typ, idx, p, 1'b1);
endtask

task automatic wait_acks(input int n, input int limit);
	int waited;
	waited = 0;
	while (ack_idx_q.size() < n && waited < limit) begin
		@(negedge clk);
		waited++;
	end
	if (ack_idx_q.size() < n)
		note_fail($sformatf("ERROR %s timed out waiting for ack number %0d", cur_test, n));
endtask

task automatic check_ack(input ffcp_index_t idx, input logic syn);
	ffcp_index_t got_idx;
	logic got_syn;
	if (ack_idx_q.size() == 0) begin
		note_fail($sformatf("ERROR %s has no ack left to check", cur_test));
	end else begin
		got_idx = ack_idx_q.pop_front();
		got_syn = ack_syn_q.pop_front();
		if (got_idx !== idx)
			note_fail($sformatf("FAIL %s ack_index expected %02h actual %02h",
				cur_test, idx, got_idx));
		if (got_syn !== syn)
			note_fail($sformatf("FAIL %s ack_syn expected %0b actual %0b", cur_test, syn, got_syn));
	end
endtask

task automatic start_test(input string name);
	cur_test = name;
	test_errors = 0;
endtask

// Let the consumer hand back every credit before the next test
task automatic finish_test();
	int waited;
	waited = 0;
	while ((credit_due_q.size() > 0 || exp_q.size() > 0) && waited < 1000) begin
		@(negedge clk);
		waited++;
	end
	if (exp_q.size() > 0)
		note_fail($sformatf("ERROR %s is missing %0d streamed bytes", cur_test, exp_q.size()));
	if (ack_idx_q.size() > 0)
		note_fail($sformatf("ERROR %s got %0d unexpected acks", cur_test, ack_idx_q.size()));
	exp_q.delete();
	ack_idx_q.delete();
	ack_syn_q.delete();
	tests_run++;
	if (test_errors == 0) begin
		$display("Test %s passed", cur_test);
	end else begin
		tests_failed++;
		$display("Test %s had %0d errors", cur_test, test_errors);
	end
endtask

task automatic test_msg_frame();
	start_test("msg_frame");
	send_good(FFCP_TYPE_MSG, 8'h07);
	wait_acks(1, 500);
	check_ack(8'h07, 1'b0);
	finish_test();
endtask

task automatic test_syn_frame();
	start_test("syn_frame");
	send_good(FFCP_TYPE_SYN, 8'h9c);
	wait_acks(1, 500);
	check_ack(8'h9c, 1'b1);
	finish_test();
endtask

task automatic test_rejected_frames();
	byte_t p[$];
	int outs_before;
	int acks_before;
	start_test("rejected_frames");
	outs_before = out_total;
	acks_before = ack_total;
	make_payload(FGP_LEN, p);
	drive_frame(16'h0800, FFCP_TYPE_MSG, 8'h11, p, 1'b1);
	drive_frame(ETHERTYPE_FFCP, FFCP_TYPE_ACK, 8'h12, p, 1'b1);
	make_payload(FGP_LEN - 1, p);
	drive_frame(ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h13, p, 1'b1);
	make_payload(FGP_LEN + 1, p);
	drive_frame(ETHERTYPE_FFCP, FFCP_TYPE_SYN, 8'h14, p, 1'b1);
	repeat (200) @(negedge clk);
	if (out_total != outs_before)
		note_fail($sformatf("FAIL %s out_valid count expected %0d actual %0d",
			cur_test, outs_before, out_total));
	if (ack_total != acks_before)
		note_fail($sformatf("FAIL %s ack count expected %0d actual %0d",
			cur_test, acks_before, ack_total));
	finish_test();
endtask

task automatic test_back_pressure();
	start_test("back_pressure");
	max_delay = 40;
	send_good(FFCP_TYPE_MSG, 8'h42);
	wait_acks(1, 1500);
	check_ack(8'h42, 1'b0);
	finish_test();
	max_delay = 5;
endtask

task automatic test_overlap();
	start_test("overlap");
	send_good(FFCP_TYPE_MSG, 8'h21);
	send_good(FFCP_TYPE_SYN, 8'h35);
	wait_acks(2, 1000);
	check_ack(8'h21, 1'b0);
	check_ack(8'h35, 1'b1);
	finish_test();
endtask

task automatic test_reset_mid_frame();
	byte_t p[$];
	start_test("reset_mid_frame");
	make_payload(FGP_LEN / 2, p);
	drive_frame(ETHERTYPE_FFCP, FFCP_TYPE_MSG, 8'h5a, p, 1'b0);
	apply_reset();
	send_good(FFCP_TYPE_MSG, 8'h5b);
	wait_acks(1, 500);
	check_ack(8'h5b, 1'b0);
	finish_test();
endtask

//--- verif/ffcp_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ffcp_rx_tb import ffcp_pkg::*; ();

	localparam int FGP_LEN = 16;
	localparam int SLOT_COUNT = 16;
	localparam int CREDIT_MAX = 4;
	localparam int NUM_TESTS = 6;
	localparam int CYCLE_NS = 8;

	logic clk = 1'b0;
	logic eth_rx_downstream_rst;
	logic ethertype_valid;
	ethertype_t ethertype;
	logic in_valid;
	byte_t in_data;
	logic frame_done;
	logic out_credit = 1'b0;
	logic out_valid;
	byte_t out_data;
	logic ack_valid;
	ffcp_index_t ack_index;
	logic ack_syn;

	// Scoreboard and consumer state
	byte_t exp_q[$];
	ffcp_index_t ack_idx_q[$];
	logic ack_syn_q[$];
	int credit_due_q[$];
	int cycle = 0;
	int outstanding = 0;
	int out_total = 0;
	int ack_total = 0;
	int max_delay = 5;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string cur_test = "startup";
	// Bytes of the current fragment seen since the last ack
	int frag_bytes = 0;
	logic prev_out_valid = 1'b0;

	always #(CYCLE_NS / 2) clk = ~clk;

	ffcp_rx_top #(
		.FGP_LEN(FGP_LEN),
		.SLOT_COUNT(SLOT_COUNT),
		.CREDIT_MAX(CREDIT_MAX)
	) ffcp_rx_top_inst (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ethertype_valid(ethertype_valid),
		.ethertype(ethertype),
		.in_valid(in_valid),
		.in_data(in_data),
		.frame_done(frame_done),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_data(out_data),
		.ack_valid(ack_valid),
		.ack_index(ack_index),
		.ack_syn(ack_syn)
	);

	bind fragment_streamer ffcp_rx_assertions #(
		.CREDIT_MAX(CREDIT_MAX)
	) ffcp_rx_assertions_inst (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.out_valid(out_valid),
		.ack_valid(ack_valid),
		.credits(credits)
	);

	// Consumer, scoreboard and ack recorder, all on the falling edge
	always @(negedge clk) begin
		int due;
		byte_t exp;
		cycle = cycle + 1;
		out_credit = 1'b0;
		if (eth_rx_downstream_rst) begin
			credit_due_q.delete();
			outstanding = 0;
			frag_bytes = 0;
		end else begin
			if (out_valid) begin
				out_total = out_total + 1;
				outstanding = outstanding + 1;
				frag_bytes = frag_bytes + 1;
				if (outstanding > CREDIT_MAX)
					note_fail($sformatf("ERROR %s has more than %0d bytes outstanding",
						cur_test, CREDIT_MAX));
				if (exp_q.size() == 0) begin
					note_fail($sformatf("ERROR %s got a byte that was never sent", cur_test));
				end else begin
					exp = exp_q.pop_front();
					if (out_data !== exp)
						note_fail($sformatf("FAIL %s out_data expected %02h actual %02h",
							cur_test, exp, out_data));
				end
				due = cycle + 1 + int'($urandom_range(max_delay, 0));
				// Only one credit pulse per cycle
				if (credit_due_q.size() > 0 && due <= credit_due_q[$])
					due = credit_due_q[$] + 1;
				credit_due_q.push_back(due);
			end
			if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
				void'(credit_due_q.pop_front());
				out_credit = 1'b1;
				outstanding = outstanding - 1;
			end
			if (ack_valid) begin
				if (!prev_out_valid || frag_bytes != FGP_LEN)
					note_fail($sformatf("ERROR %s got an ack that does not follow %s",
						cur_test, "the last byte of a fragment"));
				frag_bytes = 0;
				ack_total = ack_total + 1;
				ack_idx_q.push_back(ack_index);
				ack_syn_q.push_back(ack_syn);
			end
		end
		prev_out_valid = out_valid;
	end

	initial begin
		#(NUM_TESTS * 2000 * CYCLE_NS);
		$display("Watchdog expired during %s, the DUT stopped responding", cur_test);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h6760_e1f3));
		eth_rx_downstream_rst = 1'b1;
		ethertype_valid = 1'b0;
		ethertype = '0;
		in_valid = 1'b0;
		in_data = '0;
		frame_done = 1'b0;
		apply_reset();
		test_msg_frame();
		test_syn_frame();
		test_rejected_frames();
		test_back_pressure();
		test_overlap();
		test_reset_mid_frame();
		$display("Tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	`include "ffcp_rx_tests.svh"

endmodule

`default_nettype wire
